// File: all.f
verilog/blazePkg.sv
verilog/instrSequencer.sv
verilog/programCounter.sv
verilog/registerFile.sv
verilog/aluFlags.sv
verilog/blazeCore.sv
verification/tbClock.sv
verification/blazeCore_chk.sv
verification/tbBlaze.sv

// File: verification/blazeCore_chk.sv
/* assertions bound into the core on strobe exclusion, strobe width
   and reset state */
`timescale 1ns/1ps
`default_nettype none

module blazeCore_chk (
   input wire CLK,
   input wire RESET,
   input wire READ_STROBE,
   input wire WRITE_STROBE
);

   int failCount = 0;   // failed assertions so far

   strobesExclusive: assert property (@(posedge CLK) disable iff (RESET)
      !(READ_STROBE && WRITE_STROBE))
      else begin
         $error("read and write strobes high in the same cycle");
         failCount++;
      end

   readOneCycle: assert property (@(posedge CLK) disable iff (RESET)
      READ_STROBE |=> !READ_STROBE)
      else begin
         $error("read strobe longer than one cycle");
         failCount++;
      end

   writeOneCycle: assert property (@(posedge CLK) disable iff (RESET)
      WRITE_STROBE |=> !WRITE_STROBE)
      else begin
         $error("write strobe longer than one cycle");
         failCount++;
      end

   strobesLowAfterReset: assert property (@(posedge CLK)
      RESET |=> (!READ_STROBE && !WRITE_STROBE))
      else begin
         $error("strobe active right after reset");
         failCount++;
      end

endmodule

bind blazeCore blazeCore_chk chk (.*);

`default_nettype wire

// File: verification/tbBlaze.sv
/* testbench top with LFSR program generator, program memory, instruction-set
   model, strobe checks and reporting */
`timescale 1ns/1ps
`default_nettype none

module tbBlaze import blazePkg::*; ();

   logic CLK, clkReset, testReset, coreReset;
   wordT INSTRUCTION, IN_PORT, OUT_PORT, PORT_ID;
   addrT ADDRESS;
   logic READ_STROBE, WRITE_STROBE;

   wordT mem [4096];
   logic [15:0] lfsr;
   logic [31:0] expOut [$];   // {port id, data}
   wordT expRead [$];
   logic [31:0] expWord;
   int wp, errors, checks;
   logic timedOut;

   opcodeT arithK [5] = '{opAddXk, opAddcyXk, opSubXk, opSubcXk, opCompXk};
   opcodeT arithY [5] = '{opAddXy, opAddcyXy, opSubXy, opSubcXy, opCompXy};
   opcodeT logicK [4] = '{opAndXk, opOrXk, opXorXk, opTestXk};
   opcodeT logicY [4] = '{opAndXy, opOrXy, opXorXy, opTestXy};
   opcodeT condOps [4] = '{opJumpC, opJumpNc, opJumpZ, opJumpNz};
   opcodeT shiftOps [10] = '{opRl, opRr, opSl0, opSl1, opSla, opSlx,
                             opSr0, opSr1, opSra, opSrx};
   string kindName [5] = '{"loads", "arith", "logic", "shifts", "input"};

   assign coreReset = clkReset | testReset;

   tbClock clockGen (.CLK(CLK), .RESET(clkReset));

   blazeCore #(.startAddress('0)) DUT (
      .CLK(CLK), .RESET(coreReset), .IN_PORT(IN_PORT), .INSTRUCTION(INSTRUCTION),
      .ADDRESS(ADDRESS), .OUT_PORT(OUT_PORT), .PORT_ID(PORT_ID),
      .READ_STROBE(READ_STROBE), .WRITE_STROBE(WRITE_STROBE)
   );

   // fibonacci LFSR stepped once per bit taken
   function automatic logic [15:0] takeBits(int n);
      logic [15:0] v;
      logic fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[14:0], fb};
      end
      return v;
   endfunction

   ////////////////////////////////
   // program building
   ////////////////////////////////
   task automatic putOp(opcodeT op, logic [3:0] y, logic [3:0] x);
      mem[wp] = {1'b0, op, y, x};
      wp++;
   endtask

   task automatic putOpK(opcodeT op, logic [3:0] x, wordT k);
      mem[wp]     = {1'b1, op, 4'h0, x};
      mem[wp + 1] = k;
      wp += 2;
   endtask

   task automatic putOutput(logic [3:0] x, logic regPort);
      if (regPort)
         putOp(opOutputXy, takeBits(4), x);
      else
         putOpK(opOutputXk, x, takeBits(16));
   endtask

   // forward jump over one output when the flag test holds
   task automatic putSkip(opcodeT jop);
      logic regPort;
      regPort = takeBits(1);
      putOpK(jop, 4'h0, wordT'(wp + 2 + (regPort ? 1 : 2)));
      putOutput(takeBits(4), regPort);
   endtask

   // turn steps through every form of the kind
   task automatic putItem(int kind, int turn);
      logic [3:0] x;
      int i;
      x = takeBits(4);
      case (kind)
         0: begin
            if (takeBits(1))
               putOpK(opLoadXk, x, takeBits(16));
            else
               putOp(opLoadXy, takeBits(4), x);
            putOutput(takeBits(4), takeBits(1));
         end
         1, 2: begin
            putOpK(opLoadXk, x, takeBits(16));
            i = (kind == 1) ? turn % 5 : turn % 4;
            if (takeBits(1))
               putOpK((kind == 1) ? arithK[i] : logicK[i], x, takeBits(16));
            else
               putOp((kind == 1) ? arithY[i] : logicY[i], takeBits(4), x);
            putOutput(x, takeBits(1));
            putSkip(condOps[takeBits(2)]);
         end
         3: begin
            putOpK(opLoadXk, x, takeBits(16));
            putOp(shiftOps[turn % 10], 4'h0, x);
            putOutput(x, takeBits(1));
            putSkip(takeBits(1) ? opJumpC : opJumpNc);
         end
         default: begin
            if (takeBits(1))
               putOp(opInputXy, takeBits(4), x);
            else
               putOpK(opInputXp, x, takeBits(16));
            putOutput(x, takeBits(1));
         end
      endcase
   endtask

   ////////////////////////////////
   // instruction-set model
   ////////////////////////////////
   task automatic runModel();
      wordT r [16];
      logic z, c, alu, wr, stop;
      addrT pc, npc;
      wordT w, k, a, b, port;
      logic [16:0] t;
      opcodeT op;
      int steps;
      r = '{default: '0};
      z = 1'b0;
      c = 1'b0;
      pc = '0;
      stop = 1'b0;
      steps = 0;
      while (!stop && steps < 10000) begin
         w    = mem[pc];
         k    = mem[pc + 1];
         op   = opcodeT'(w[14:8]);
         a    = r[w[3:0]];
         b    = w[15] ? k : r[w[7:4]];     // constant form when a word follows
         port = b;
         npc  = pc + 1 + w[15];
         alu  = 1'b1;
         wr   = 1'b1;
         t    = '0;
         case (op)
            opAddXk, opAddXy:     t = {1'b0, a} + b;
            opAddcyXk, opAddcyXy: t = {1'b0, a} + b + c;
            opSubXk, opSubXy:     t = {1'b0, a} - b;
            opSubcXk, opSubcXy:   t = {1'b0, a} - b - c;
            opCompXk, opCompXy: begin
               t  = {1'b0, a} - b;
               wr = 1'b0;
            end
            opAndXk, opAndXy: t = {1'b0, a & b};
            opOrXk, opOrXy:   t = {1'b0, a | b};
            opXorXk, opXorXy: t = {1'b0, a ^ b};
            opTestXk, opTestXy: begin
               t  = {^(a & b), a & b};     // carry is parity
               wr = 1'b0;
            end
            opRl:  t = {a[15], a[14:0], a[15]};
            opRr:  t = {a[0], a[0], a[15:1]};
            opSl0: t = {a[15], a[14:0], 1'b0};
            opSl1: t = {a[15], a[14:0], 1'b1};
            opSla: t = {a[15], a[14:0], c};
            opSlx: t = {a[15], a[14:0], a[0]};
            opSr0: t = {a[0], 1'b0, a[15:1]};
            opSr1: t = {a[0], 1'b1, a[15:1]};
            opSra: t = {a[0], c, a[15:1]};
            opSrx: t = {a[0], a[15], a[15:1]};
            opLoadXk, opLoadXy: begin
               alu = 1'b0;
               r[w[3:0]] = b;
            end
            opInputXy, opInputXp: begin
               alu = 1'b0;
               expRead.push_back(port);
               r[w[3:0]] = port ^ 16'hA5C3;
            end
            opOutputXy, opOutputXk: begin
               alu = 1'b0;
               expOut.push_back({port, a});
            end
            opJump, opJumpC, opJumpNc, opJumpZ, opJumpNz: begin
               alu = 1'b0;
               if (op == opJump && k[11:0] == pc)
                  stop = 1'b1;            // jump to self ends the program
               if (op == opJump || (op == opJumpC && c) || (op == opJumpNc && !c) ||
                   (op == opJumpZ && z) || (op == opJumpNz && !z))
                  npc = k[11:0];
            end
            default: alu = 1'b0;
         endcase
         if (alu) begin
            z = (t[15:0] == 16'h0000);
            c = t[16];
            if (wr)
               r[w[3:0]] = t[15:0];
         end
         pc = npc;
         steps++;
      end
   endtask

   // inputs change on the falling edge
   always @(negedge CLK) begin
      INSTRUCTION <= mem[ADDRESS];
      IN_PORT     <= READ_STROBE ? (PORT_ID ^ 16'hA5C3) : '0;
   end

   ////////////////////////////////
   // strobe checks
   ////////////////////////////////
   always @(negedge CLK) begin
      if (WRITE_STROBE) begin
         assert (expOut.size() > 0) else begin
            $display("write strobe seen with no output left in the model");
            errors++;
         end
         if (expOut.size() > 0) begin
            expWord = expOut.pop_front();
            checks++;
            assert (PORT_ID == expWord[31:16]) else begin
               $display("FAILED PORT_ID got %h expected %h", PORT_ID, expWord[31:16]);
               errors++;
            end
            assert (OUT_PORT == expWord[15:0]) else begin
               $display("FAILED OUT_PORT got %h expected %h", OUT_PORT, expWord[15:0]);
               errors++;
            end
         end
      end
      if (READ_STROBE) begin
         assert (expRead.size() > 0) else begin
            $display("read strobe seen with no input left in the model");
            errors++;
         end
         if (expRead.size() > 0) begin
            expWord = {16'h0000, expRead.pop_front()};
            checks++;
            assert (PORT_ID == expWord[15:0]) else begin
               $display("FAILED PORT_ID got %h expected %h", PORT_ID, expWord[15:0]);
               errors++;
            end
         end
      end
   end

   task automatic runTest(int n, int kind);
      int cycles, limit, errStart, writes, reads;
      addrT endAddr;
      errStart = errors;
      @(negedge CLK);
      testReset = 1'b1;
      wp = 0;
      for (int i = 0; i < 8; i++)
         putItem(kind, 8 * (n / 5) + i);
      endAddr = addrT'(wp);
      putOpK(opJump, 4'h0, wordT'(wp));
      limit = 12 * wp + 200;
      expOut.delete();
      expRead.delete();
      runModel();
      writes = expOut.size();
      reads  = expRead.size();
      repeat (3) @(negedge CLK);
      testReset = 1'b0;
      cycles = 0;
      while (ADDRESS != addrT'(endAddr + 2) && cycles <= limit) begin
         @(negedge CLK);
         cycles++;
      end
      if (cycles > limit) begin
         timedOut = 1'b1;
         $display("timeout: test %0d never reached its final jump", n);
      end else begin
         assert (expOut.size() == 0 && expRead.size() == 0) else begin
            $display("test %0d ended with strobes missing", n);
            errors++;
         end
      end
      $display("test %0d %s: %0d writes, %0d reads, %0d errors", n, kindName[kind],
               writes, reads, errors - errStart);
   endtask

   initial begin
      lfsr        = 16'd62;
      errors      = 0;
      checks      = 0;
      timedOut    = 1'b0;
      testReset   = 1'b1;
      INSTRUCTION = '0;
      IN_PORT     = '0;
      for (int i = 0; i < 4096; i++)
         mem[i] = wordT'(i * 37) ^ 16'hC3A5;   // unused words never run
      for (int n = 0; n < 10 && !timedOut; n++)
         runTest(n, n % 5);
      errors += DUT.chk.failCount;
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0 && !timedOut)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/tbClock.sv
/* testbench clock, 8 ns period, and power-on reset held for 3 cycles */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
   output logic CLK,
   output logic RESET
);

   initial begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   initial begin
      RESET = 1'b1;
      repeat (3) @(posedge CLK);
      @(negedge CLK);
      RESET = 1'b0;
   end

endmodule

`default_nettype wire

// File: verilog/aluFlags.sv
/* ALU with its result register, zero and carry flag update */
`timescale 1ns/1ps
`default_nettype none

module aluFlags import blazePkg::*; (
   input  logic  CLK,
   input  logic  RESET,
   input  ctrlT  ctrl,
   input  wordT  regA,
   input  wordT  operandB,
   output wordT  aluResult,
   output flagsT flags
);

   localparam int msb = wordWidth - 1;

   logic [wordWidth:0] aluOut;    // bit 16 holds carry or borrow
   logic [wordWidth:0] aluOutQ;
   logic  shiftOut;
   logic  resultZero;
   flagsT flagsD;

   ////////////////////////////////
   // ALU
   ////////////////////////////////
   always_comb begin
      case (ctrl.aluOp)
         aluNothing: aluOut = aluOutQ;      // hold last result
         aluAdd:     aluOut = regA + operandB;
         aluAddc:    aluOut = regA + operandB + flags.carry;
         aluSub:     aluOut = regA - operandB;
         aluSubc:    aluOut = regA - operandB - flags.carry;
         aluAnd:     aluOut = {1'b0, regA & operandB};
         aluOr:      aluOut = {1'b0, regA | operandB};
         aluXor:     aluOut = {1'b0, regA ^ operandB};
         aluRl:      aluOut = {1'b0, regA[msb-1:0], regA[msb]};
         aluRr:      aluOut = {1'b0, regA[0], regA[msb:1]};
         aluSl0:     aluOut = {1'b0, regA[msb-1:0], 1'b0};
         aluSl1:     aluOut = {1'b0, regA[msb-1:0], 1'b1};
         aluSla:     aluOut = {1'b0, regA[msb-1:0], flags.carry};
         aluSlx:     aluOut = {1'b0, regA[msb-1:0], regA[0]};
         aluSr0:     aluOut = {1'b0, 1'b0, regA[msb:1]};
         aluSr1:     aluOut = {1'b0, 1'b1, regA[msb:1]};
         aluSra:     aluOut = {1'b0, flags.carry, regA[msb:1]};
         aluSrx:     aluOut = {1'b0, regA[msb], regA[msb:1]};
         default:    aluOut = '0;
      endcase
   end

   // bit that leaves the word on a shift or rotate
   assign shiftOut = (ctrl.aluOp inside {aluRl, aluSl0, aluSl1, aluSla, aluSlx}) ?
                     regA[msb] : regA[0];

   always_ff @(posedge CLK) begin
      aluOutQ <= aluOut;
   end

   assign aluResult = aluOut[msb:0];

   ////////////////////////////////
   // zero and carry
   ////////////////////////////////
   assign resultZero = ~|aluOut[msb:0];

   always_comb begin
      case (ctrl.flagSrc)
         flagArith: flagsD = '{zero: resultZero, carry: aluOut[wordWidth]};
         flagLogic: flagsD = '{zero: resultZero, carry: 1'b0};
         flagShift: flagsD = '{zero: resultZero, carry: shiftOut};
         default:   flagsD = '{zero: resultZero, carry: ^aluOut[msb:0]}; // test, parity
      endcase
   end

   always_ff @(posedge CLK or posedge RESET) begin
      if (RESET)
         flags <= '0;
      else if (ctrl.loadFlags)
         flags <= flagsD;
   end

endmodule

`default_nettype wire

// File: verilog/blazeCore.sv
/* blaze core top: sequencer, program counter, register file and ALU */
`timescale 1ns/1ps
`default_nettype none

module blazeCore import blazePkg::*; #(
   parameter addrT startAddress = '0
) (
   input  logic CLK,
   input  logic RESET,
   input  wordT IN_PORT,
   input  wordT INSTRUCTION,
   output addrT ADDRESS,
   output wordT OUT_PORT,
   output wordT PORT_ID,
   output logic READ_STROBE,
   output logic WRITE_STROBE
);

   ctrlT  ctrl;
   flagsT flags;
   instrT instr;
   wordT  constWord;
   wordT  regA;
   wordT  operandB;
   wordT  aluResult;

   instrSequencer uSeq (
      .CLK   (CLK),
      .RESET (RESET),
      .instr (instr),
      .flags (flags),
      .ctrl  (ctrl)
   );

   programCounter #(.startAddress(startAddress)) uPc (
      .CLK         (CLK),
      .RESET       (RESET),
      .INSTRUCTION (INSTRUCTION),
      .ctrl        (ctrl),
      .ADDRESS     (ADDRESS),
      .instr       (instr),
      .constWord   (constWord)
   );

   registerFile uRf (
      .CLK       (CLK),
      .RESET     (RESET),
      .IN_PORT   (IN_PORT),
      .ctrl      (ctrl),
      .instr     (instr),
      .constWord (constWord),
      .aluResult (aluResult),
      .regA      (regA),
      .operandB  (operandB),
      .OUT_PORT  (OUT_PORT),
      .PORT_ID   (PORT_ID)
   );

   aluFlags uAlu (
      .CLK       (CLK),
      .RESET     (RESET),
      .ctrl      (ctrl),
      .regA      (regA),
      .operandB  (operandB),
      .aluResult (aluResult),
      .flags     (flags)
   );

   assign READ_STROBE  = ctrl.readStrobe;   // registered in the sequencer
   assign WRITE_STROBE = ctrl.writeStrobe;

endmodule

`default_nettype wire

// File: verilog/blazePkg.sv
/* shared types of the blaze core: widths, instruction fields, opcodes,
   ALU operations, control word and flags */
`default_nettype none

package blazePkg;

   localparam int wordWidth    = 16;
   localparam int addrWidth    = 12;
   localparam int opcodeWidth  = 7;
   localparam int regAddrWidth = 4;
   localparam int regCount     = 2 ** regAddrWidth;

   typedef logic [wordWidth-1:0]    wordT;
   typedef logic [addrWidth-1:0]    addrT;
   typedef logic [regAddrWidth-1:0] regAddrT;

   // opcode values follow the original encoding, even codes only
   typedef enum logic [opcodeWidth-1:0] {
      opNop      = 7'h00, opAddXk    = 7'h02, opAddXy    = 7'h04,
      opAddcyXk  = 7'h06, opAddcyXy  = 7'h08, opAndXk    = 7'h0A,
      opAndXy    = 7'h0C, opCompXk   = 7'h18, opCompXy   = 7'h1A,
      opInputXy  = 7'h20, opInputXp  = 7'h22, opJump     = 7'h24,
      opJumpC    = 7'h26, opJumpNc   = 7'h28, opJumpZ    = 7'h2A,
      opJumpNz   = 7'h2C, opLoadXk   = 7'h2E, opLoadXy   = 7'h30,
      opOrXk     = 7'h32, opOrXy     = 7'h34, opOutputXy = 7'h36,
      opOutputXk = 7'h38, opRl       = 7'h48, opRr       = 7'h4A,
      opSl0      = 7'h4C, opSl1      = 7'h4E, opSla      = 7'h50,
      opSlx      = 7'h52, opSr0      = 7'h54, opSr1      = 7'h56,
      opSra      = 7'h58, opSrx      = 7'h5A, opSubXk    = 7'h5C,
      opSubXy    = 7'h5E, opSubcXk   = 7'h60, opSubcXy   = 7'h62,
      opTestXk   = 7'h64, opTestXy   = 7'h66, opXorXk    = 7'h68,
      opXorXy    = 7'h6A
   } opcodeT;

   typedef struct packed {
      logic    hasConst;   // constant word follows
      opcodeT  opcode;
      regAddrT regY;
      regAddrT regX;
   } instrT;

   typedef enum logic [4:0] {
      aluNothing = 5'h00, aluAdd = 5'h01, aluAddc = 5'h02, aluAnd = 5'h03,
      aluSub     = 5'h04, aluOr  = 5'h05, aluRl   = 5'h06, aluRr  = 5'h07,
      aluSl0     = 5'h08, aluSl1 = 5'h09, aluSla  = 5'h0A, aluSlx = 5'h0B,
      aluSr0     = 5'h0C, aluSr1 = 5'h0D, aluSra  = 5'h0E, aluSrx = 5'h0F,
      aluXor     = 5'h10, aluSubc = 5'h11
   } aluOpT;

   typedef enum logic [1:0] {rfAlu, rfInPort, rfConst, rfRegY} rfSrcT;
   typedef enum logic [1:0] {flagArith, flagLogic, flagShift, flagTest} flagSrcT;
   typedef enum logic {pcInc, pcConst} pcSrcT;

   ////////////////////////////////
   // control word, one per cycle
   ////////////////////////////////
   typedef struct packed {
      logic    loadIr;
      logic    loadPc;
      pcSrcT   pcSrc;
      logic    loadConst;
      logic    writeRf;
      rfSrcT   rfSrc;
      logic    selConstB;      // ALU operand B from constant
      logic    selConstPort;   // port id from constant
      aluOpT   aluOp;
      logic    loadFlags;
      flagSrcT flagSrc;
      logic    enablePortId;
      logic    enableInPort;
      logic    enableOutPort;
      logic    readStrobe;
      logic    writeStrobe;
   } ctrlT;

   typedef struct packed {
      logic zero;
      logic carry;
   } flagsT;

endpackage

`default_nettype wire

// File: verilog/instrSequencer.sv
/* instruction sequencer: state machine that decodes the instruction register
   and registers one control word per cycle */
`timescale 1ns/1ps
`default_nettype none

module instrSequencer import blazePkg::*; (
   input  logic  CLK,
   input  logic  RESET,
   input  instrT instr,
   input  flagsT flags,
   output ctrlT  ctrl
);

   typedef enum logic [2:0] {
      sFetch, sDecode, sConst1, sConst2, sExecute, sInput2, sOutput2, sEndit
   } stateT;

   stateT stateQ, stateD;
   ctrlT  ctrlD;

   // forms whose operand B is the constant word
   function automatic logic constOperand(opcodeT op);
      return op inside {opAddXk, opAddcyXk, opAndXk, opCompXk, opOrXk,
                        opSubXk, opSubcXk, opTestXk, opXorXk};
   endfunction

   always_ff @(posedge CLK or posedge RESET) begin
      if (RESET) begin
         stateQ      <= sFetch;
         ctrl        <= '0;
         ctrl.loadIr <= 1'b1;     // first fetch right out of reset
         ctrl.loadPc <= 1'b1;
      end else begin
         stateQ <= stateD;
         ctrl   <= ctrlD;
      end
   end

   ////////////////////////////////
   // next state and control word
   ////////////////////////////////
   always_comb begin
      logic takeJump;
      logic writesX;
      logic isAlu;
      ctrlD    = '0;
      stateD   = sFetch;
      takeJump = 1'b0;
      writesX  = 1'b1;
      isAlu    = 1'b0;
      case (stateQ)
         sFetch: stateD = sDecode;       // IR and PC load during this cycle
         sDecode: begin
            if (instr.hasConst) begin
               ctrlD.loadConst = 1'b1;
               stateD          = sConst1;
            end else begin
               stateD = sExecute;
            end
         end
         sConst1: begin
            ctrlD.loadPc = 1'b1;        // step past the constant word
            stateD       = sConst2;
         end
         sConst2: stateD = sExecute;
         sExecute: begin
            stateD          = sEndit;
            ctrlD.selConstB = constOperand(instr.opcode);
            case (instr.opcode)
               opAddXk, opAddXy:     ctrlD.aluOp = aluAdd;
               opAddcyXk, opAddcyXy: ctrlD.aluOp = aluAddc;
               opSubXk, opSubXy:     ctrlD.aluOp = aluSub;
               opSubcXk, opSubcXy:   ctrlD.aluOp = aluSubc;
               opRl:                 ctrlD.aluOp = aluRl;
               opRr:                 ctrlD.aluOp = aluRr;
               opSl0:                ctrlD.aluOp = aluSl0;
               opSl1:                ctrlD.aluOp = aluSl1;
               opSla:                ctrlD.aluOp = aluSla;
               opSlx:                ctrlD.aluOp = aluSlx;
               opSr0:                ctrlD.aluOp = aluSr0;
               opSr1:                ctrlD.aluOp = aluSr1;
               opSra:                ctrlD.aluOp = aluSra;
               opSrx:                ctrlD.aluOp = aluSrx;
               opAndXk, opAndXy: begin
                  ctrlD.aluOp   = aluAnd;
                  ctrlD.flagSrc = flagLogic;
               end
               opOrXk, opOrXy: begin
                  ctrlD.aluOp   = aluOr;
                  ctrlD.flagSrc = flagLogic;
               end
               opXorXk, opXorXy: begin
                  ctrlD.aluOp   = aluXor;
                  ctrlD.flagSrc = flagLogic;
               end
               opCompXk, opCompXy: begin
                  ctrlD.aluOp = aluSub;       // flags only
                  writesX     = 1'b0;
               end
               opTestXk, opTestXy: begin
                  ctrlD.aluOp   = aluAnd;
                  ctrlD.flagSrc = flagTest;
                  writesX       = 1'b0;
               end
               opLoadXk: begin
                  ctrlD.rfSrc   = rfConst;
                  ctrlD.writeRf = 1'b1;
               end
               opLoadXy: begin
                  ctrlD.rfSrc   = rfRegY;
                  ctrlD.writeRf = 1'b1;
               end
               opInputXy, opInputXp: begin
                  ctrlD.selConstPort = (instr.opcode == opInputXp);
                  ctrlD.enablePortId = 1'b1;
                  ctrlD.enableInPort = 1'b1;
                  stateD             = sInput2;
               end
               opOutputXy, opOutputXk: begin
                  ctrlD.selConstPort  = (instr.opcode == opOutputXk);
                  ctrlD.enablePortId  = 1'b1;
                  ctrlD.enableOutPort = 1'b1;
                  stateD              = sOutput2;
               end
               opJump:   takeJump = 1'b1;
               opJumpC:  takeJump = flags.carry;
               opJumpNc: takeJump = !flags.carry;
               opJumpZ:  takeJump = flags.zero;
               opJumpNz: takeJump = !flags.zero;
               default: ;                     // nop and unused codes
            endcase
            isAlu = (ctrlD.aluOp != aluNothing);
            if (ctrlD.aluOp inside {[aluRl:aluSrx]})
               ctrlD.flagSrc = flagShift;
            ctrlD.loadFlags = isAlu;
            ctrlD.writeRf   = ctrlD.writeRf | (isAlu & writesX);
            if (takeJump) begin
               ctrlD.loadPc = 1'b1;           // PC takes the constant in endit
               ctrlD.pcSrc  = pcConst;
            end
         end
         sInput2: begin
            ctrlD.selConstPort = ctrl.selConstPort;
            ctrlD.enablePortId = 1'b1;
            ctrlD.enableInPort = 1'b1;
            ctrlD.readStrobe   = 1'b1;
            ctrlD.rfSrc        = rfInPort;
            ctrlD.writeRf      = 1'b1;       // sampled at end of strobe cycle
            stateD             = sEndit;
         end
         sOutput2: begin
            ctrlD.selConstPort  = ctrl.selConstPort;
            ctrlD.enablePortId  = 1'b1;
            ctrlD.enableOutPort = 1'b1;
            ctrlD.writeStrobe   = 1'b1;
            stateD              = sEndit;
         end
         sEndit: begin
            ctrlD.loadIr = 1'b1;
            ctrlD.loadPc = 1'b1;
            stateD       = sFetch;
         end
         default: stateD = sFetch;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/programCounter.sv
/* program counter with next-address select, instruction register
   and constant register */
`timescale 1ns/1ps
`default_nettype none

module programCounter import blazePkg::*; #(
   parameter addrT startAddress = '0
) (
   input  logic  CLK,
   input  logic  RESET,
   input  wordT  INSTRUCTION,
   input  ctrlT  ctrl,
   output addrT  ADDRESS,
   output instrT instr,
   output wordT  constWord
);

   addrT  pc, pcNext;
   instrT ir;
   wordT  constQ;

   // jump target comes from the trailing constant word
   assign pcNext = (ctrl.pcSrc == pcConst) ? constQ[addrWidth-1:0] : pc + 1'b1;

   always_ff @(posedge CLK or posedge RESET) begin
      if (RESET) begin
         pc <= startAddress;
         ir <= '0;
      end else begin
         if (ctrl.loadPc)
            pc <= pcNext;
         if (ctrl.loadIr)
            ir <= instrT'(INSTRUCTION);
      end
   end

   always_ff @(posedge CLK) begin
      if (ctrl.loadConst)
         constQ <= INSTRUCTION;   // word at PC while IR is decoded
   end

   assign ADDRESS   = pc;
   assign instr     = ir;
   assign constWord = constQ;

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
/* sixteen data registers, write-data and operand B select,
   port id and output port gating */
`timescale 1ns/1ps
`default_nettype none

module registerFile import blazePkg::*; (
   input  logic  CLK,
   input  logic  RESET,
   input  wordT  IN_PORT,
   input  ctrlT  ctrl,
   input  instrT instr,
   input  wordT  constWord,
   input  wordT  aluResult,
   output wordT  regA,
   output wordT  operandB,
   output wordT  OUT_PORT,
   output wordT  PORT_ID
);

   wordT regs [regCount];
   wordT regY;
   wordT writeData;
   wordT portSrc;

   assign regA     = regs[instr.regX];
   assign regY     = regs[instr.regY];
   assign operandB = ctrl.selConstB ? constWord : regY;

   always_comb begin
      case (ctrl.rfSrc)
         rfAlu:    writeData = aluResult;
         rfInPort: writeData = IN_PORT & {wordWidth{ctrl.enableInPort}};
         rfConst:  writeData = constWord;
         default:  writeData = regY;         // register to register load
      endcase
   end

   always_ff @(posedge CLK or posedge RESET) begin
      if (RESET)
         regs <= '{default: '0};
      else if (ctrl.writeRf)
         regs[instr.regX] <= writeData;
   end

   ////////////////////////////////
   // port side, zero when idle
   ////////////////////////////////
   assign portSrc  = ctrl.selConstPort ? constWord : operandB;
   assign PORT_ID  = portSrc & {wordWidth{ctrl.enablePortId}};
   assign OUT_PORT = regA & {wordWidth{ctrl.enableOutPort}};

endmodule

`default_nettype wire
